// File: verilog/fp_adder_cfg.svh
`ifndef FP_ADDER_CFG_SVH
`define FP_ADDER_CFG_SVH

// Width of the biased exponent field of a binary32 number
`define FP_EXP_W 8

// Width of the stored fraction, without the hidden bit
`define FP_FRAC_W 23

// Exponent bias of the binary32 format
`define FP_BIAS 127

// Working significand width is sign, hidden bit, fraction and one guard bit
// The alignment shift saturates at this value as well
`define FP_SIG_W (`FP_FRAC_W + 3)

// Number of register stages between the start strobe and the done strobe
`define FP_ADD_LATENCY 4

`endif

// File: verilog/fp_format_pkg.sv
`include "fp_adder_cfg.svh"

package fp_format_pkg;

	// A binary32 number exactly as it appears on the ports of the adder
	typedef logic [`FP_EXP_W+`FP_FRAC_W:0] fp_word_t;

	// Biased exponent field
	// All ones marks an infinity or a NaN, all zeros marks zero or a subnormal
	typedef logic [`FP_EXP_W-1:0] fp_exp_t;

	// Stored fraction, the hidden bit is not part of it
	typedef logic [`FP_FRAC_W-1:0] fp_frac_t;

	// Field view of a binary32 number, same bit layout as fp_word_t
	// A word can be assigned to this struct and back without any conversion
	typedef struct packed {
		logic sign;
		fp_exp_t exponent;
		fp_frac_t fraction;
	} fp_fields_t;

endpackage

// File: verilog/fp_adder_pkg.sv
`include "fp_adder_cfg.svh"

package fp_adder_pkg;

	import fp_format_pkg::*;

	// Signed working significand in two's complement
	// Bit 25 is the sign, bit 24 the hidden bit, then the fraction and one guard bit
	typedef logic signed [`FP_SIG_W-1:0] sig_t;

	// Alignment shift, saturated at the significand width so that six bits suffice
	typedef logic [5:0] shift_t;

	// Unsigned magnitude of the sum with the leading one position at the top bit
	typedef logic [`FP_SIG_W-1:0] mag_t;

	// Special case flags worked out from the operands in stage 1
	// They travel with the data and override the arithmetic at the end
	typedef struct packed {
		logic result_is_inf;
		logic result_is_nan;
		logic inf_sign;
	} fp_special_t;

	// Stage 1 output, significand2 always belongs to the smaller exponent
	typedef struct packed {
		shift_t align_shift;
		sig_t significand1;
		sig_t significand2;
		fp_exp_t exponent1;
		fp_exp_t exponent2;
		logic exponent2_larger;
		fp_special_t special;
	} add1_t;

	// Stage 2 output, both significands aligned to the result exponent
	typedef struct packed {
		fp_exp_t exponent;
		sig_t significand1;
		sig_t significand2;
		fp_special_t special;
	} add2_t;

	// Stage 3 output, sum in sign and magnitude form
	typedef struct packed {
		fp_exp_t exponent;
		logic sum_sign;
		mag_t magnitude;
		fp_special_t special;
	} add3_t;

endpackage

// File: verilog/fp_adder_ctrl.sv
`timescale 1ns/1ps
`include "fp_adder_cfg.svh"

module fp_adder_ctrl (
	input logic clk,
	input logic reset_n,
	input logic start,
	output logic done,
	output logic busy
);

	localparam int LATENCY = `FP_ADD_LATENCY;

	// One valid bit per pipeline stage, bit 0 goes with stage 1
	logic [LATENCY-1:0] valid_chain;

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			valid_chain <= '0;
		else
			valid_chain <= {valid_chain[LATENCY-2:0], start};
	end

	// The last bit lines up with the result registers of stage 4
	assign done = valid_chain[LATENCY-1];

	// Anything still in flight keeps the adder busy
	assign busy = |valid_chain;

	// Every start has to come out as done after the full pipeline depth
	assert property (@(posedge clk) disable iff (!reset_n)
		start |-> ##LATENCY done)
		else $error("fp_adder_ctrl: done missing %0d cycles after start", LATENCY);

endmodule

// File: verilog/fp_adder_stage1.sv
`timescale 1ns/1ps
`include "fp_adder_cfg.svh"

module fp_adder_stage1
	import fp_format_pkg::*, fp_adder_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input fp_word_t operand1,
	input fp_word_t operand2,
	output add1_t add1
);

	// Shifting by the full significand width already clears every value bit
	localparam fp_exp_t MAX_SHIFT = fp_exp_t'(`FP_SIG_W);

	fp_fields_t fields1;
	fp_fields_t fields2;
	sig_t sig1;
	sig_t sig2;
	logic nan1;
	logic nan2;
	logic inf1;
	logic inf2;
	logic any_nan;
	logic exponent2_larger;
	fp_exp_t exp_diff;
	add1_t add1_next;

	// Converts one operand into a signed working significand
	// A zero exponent flushes the operand to zero, so subnormals vanish here
	function automatic sig_t to_significand(input fp_fields_t value);
		sig_t magnitude;
		if (value.exponent == '0)
			magnitude = '0;
		else
			magnitude = {2'b01, value.fraction, 1'b0};
		return value.sign ? -magnitude : magnitude;
	endfunction

	assign fields1 = operand1;
	assign fields2 = operand2;
	assign sig1 = to_significand(fields1);
	assign sig2 = to_significand(fields2);

	// An all ones exponent is an infinity with a zero fraction and a NaN otherwise
	assign nan1 = (&fields1.exponent) && (|fields1.fraction);
	assign nan2 = (&fields2.exponent) && (|fields2.fraction);
	assign inf1 = (&fields1.exponent) && !(|fields1.fraction);
	assign inf2 = (&fields2.exponent) && !(|fields2.fraction);

	// Opposite infinities have no defined sum, so they count as NaN too
	assign any_nan = nan1 || nan2 || (inf1 && inf2 && (fields1.sign != fields2.sign));

	always_comb
	begin
		exponent2_larger = fields2.exponent > fields1.exponent;
		if (exponent2_larger)
			exp_diff = fields2.exponent - fields1.exponent;
		else
			exp_diff = fields1.exponent - fields2.exponent;

		// Anything beyond the significand width shifts to all sign bits anyway
		if (exp_diff > MAX_SHIFT)
			add1_next.align_shift = shift_t'(MAX_SHIFT);
		else
			add1_next.align_shift = shift_t'(exp_diff);

		// Swap so that the operand with the smaller exponent is the one shifted
		add1_next.significand1 = exponent2_larger ? sig2 : sig1;
		add1_next.significand2 = exponent2_larger ? sig1 : sig2;
		add1_next.exponent1 = fields1.exponent;
		add1_next.exponent2 = fields2.exponent;
		add1_next.exponent2_larger = exponent2_larger;

		add1_next.special.result_is_nan = any_nan;
		add1_next.special.result_is_inf = (inf1 || inf2) && !any_nan;
		// With two infinities left here they share a sign, so either one is right
		add1_next.special.inf_sign = inf1 ? fields1.sign : fields2.sign;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			add1 <= '0;
		else
			add1 <= add1_next;
	end

endmodule

// File: verilog/fp_adder_stage2.sv
`timescale 1ns/1ps
`include "fp_adder_cfg.svh"

module fp_adder_stage2
	import fp_adder_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input add1_t add1,
	output add2_t add2
);

	add2_t add2_next;

	always_comb
	begin
		// The larger exponent becomes the exponent of the unnormalized sum
		if (add1.exponent2_larger)
			add2_next.exponent = add1.exponent2;
		else
			add2_next.exponent = add1.exponent1;

		// The larger operand needs no alignment
		add2_next.significand1 = add1.significand1;

		// Sign extending shift keeps a negative significand negative
		// A fully shifted negative value ends up as minus one guard unit
		add2_next.significand2 = $signed(add1.significand2) >>> add1.align_shift;

		add2_next.special = add1.special;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			add2 <= '0;
		else
			add2 <= add2_next;
	end

	// Stage 1 must saturate the shift, a wider shift means the compare went wrong
	assert property (@(posedge clk) disable iff (!reset_n)
		add1.align_shift <= shift_t'(`FP_SIG_W))
		else $error("fp_adder_stage2: align_shift %0d above saturation", add1.align_shift);

endmodule

// File: verilog/fp_adder_stage3.sv
`timescale 1ns/1ps

module fp_adder_stage3
	import fp_format_pkg::*, fp_adder_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input add2_t add2,
	output add3_t add3
);

	// One extra bit holds the carry out of the significand add
	logic [$bits(sig_t):0] sum_full;
	mag_t abs_sum;
	logic carry;
	add3_t add3_next;

	always_comb
	begin
		// Sign extend both significands by one bit before adding
		sum_full = {add2.significand1[$bits(sig_t)-1], add2.significand1}
			+ {add2.significand2[$bits(sig_t)-1], add2.significand2};

		// The magnitude never reaches the top bit of sum_full, so it fits in mag_t
		abs_sum = mag_t'(sum_full[$bits(sig_t)] ? -sum_full : sum_full);
		carry = abs_sum[$bits(mag_t)-1];

		add3_next.sum_sign = sum_full[$bits(sig_t)];

		// The magnitude leaves with its hidden position at the top bit
		// A carry already sits there and raises the exponent by one
		// Without a carry the value moves up one place and the exponent stays
		add3_next.exponent = carry ? add2.exponent + fp_exp_t'(1) : add2.exponent;
		add3_next.magnitude = carry ? abs_sum : abs_sum << 1;

		add3_next.special = add2.special;
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
			add3 <= '0;
		else
			add3 <= add3_next;
	end

endmodule

// File: verilog/fp_adder_stage4.sv
`timescale 1ns/1ps
`include "fp_adder_cfg.svh"

module fp_adder_stage4
	import fp_format_pkg::*, fp_adder_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input add3_t add3,
	output fp_word_t result,
	output logic result_is_inf,
	output logic result_is_nan
);

	// All ones exponent of infinities and NaNs, twice the bias plus one
	localparam fp_exp_t EXP_MAX = fp_exp_t'(2 * `FP_BIAS + 1);
	// Enough bits to count up to the full magnitude width
	localparam int LZ_W = $clog2($bits(mag_t) + 1);

	logic [LZ_W-1:0] lead_zeros;
	mag_t normalized;
	// Two extra bits so that the adjusted exponent can go negative or past 255
	logic signed [`FP_EXP_W+1:0] exp_norm;
	logic underflow;
	logic overflow;
	fp_fields_t packed_result;
	logic inf_next;
	logic nan_next;

	// Leading zero count, the highest set bit is the last one found
	function automatic logic [LZ_W-1:0] count_lead_zeros(input mag_t value);
		logic [LZ_W-1:0] count;
		count = '0;
		for (int i = 0; i < $bits(mag_t); i++)
		begin
			if (value[i])
				count = LZ_W'($bits(mag_t) - 1 - i);
		end
		return count;
	endfunction

	assign lead_zeros = count_lead_zeros(add3.magnitude);
	assign normalized = add3.magnitude << lead_zeros;
	assign exp_norm = $signed({2'b00, add3.exponent})
		- $signed({{(`FP_EXP_W + 2 - LZ_W){1'b0}}, lead_zeros});

	// Biased exponent below one would be subnormal and is flushed
	assign underflow = exp_norm[`FP_EXP_W+1] || (exp_norm == '0);
	assign overflow = exp_norm >= {2'b00, EXP_MAX};

	always_comb
	begin
		packed_result = '0;
		inf_next = 1'b0;
		nan_next = 1'b0;

		// Special operands win over whatever the arithmetic produced
		if (add3.special.result_is_nan)
		begin
			// Quiet NaN with only the top fraction bit set
			packed_result.exponent = EXP_MAX;
			packed_result.fraction = {1'b1, {(`FP_FRAC_W - 1){1'b0}}};
			nan_next = 1'b1;
		end
		else if (add3.special.result_is_inf)
		begin
			packed_result.sign = add3.special.inf_sign;
			packed_result.exponent = EXP_MAX;
			inf_next = 1'b1;
		end
		else if ((add3.magnitude != '0) && !underflow)
		begin
			packed_result.sign = add3.sum_sign;
			if (overflow)
			begin
				packed_result.exponent = EXP_MAX;
				inf_next = 1'b1;
			end
			else
			begin
				packed_result.exponent = exp_norm[`FP_EXP_W-1:0];
				// Drop the hidden bit at the top and truncate the guard bits
				packed_result.fraction = normalized[$bits(mag_t)-2 -: `FP_FRAC_W];
			end
		end
		// A zero sum or an underflow keeps the cleared value, which is +0
	end

	always_ff @(posedge clk or negedge reset_n)
	begin
		if (!reset_n)
		begin
			result <= '0;
			result_is_inf <= 1'b0;
			result_is_nan <= 1'b0;
		end
		else
		begin
			result <= packed_result;
			result_is_inf <= inf_next;
			result_is_nan <= nan_next;
		end
	end

	// Stage 1 must never flag a result as both infinite and NaN
	assert property (@(posedge clk) disable iff (!reset_n)
		!(add3.special.result_is_inf && add3.special.result_is_nan))
		else $error("fp_adder_stage4: inf and nan flags high together");

endmodule

// File: verilog/fp_adder.sv
`timescale 1ns/1ps

module fp_adder
	import fp_format_pkg::*, fp_adder_pkg::*;
(
	input logic clk,
	input logic reset_n,
	input logic start,
	input fp_word_t operand1,
	input fp_word_t operand2,
	output logic done,
	output logic busy,
	output fp_word_t result,
	output logic result_is_inf,
	output logic result_is_nan
);

	// Structs handed from one stage register to the next
	add1_t add1;
	add2_t add2;
	add3_t add3;

	// Validity lives only in the control module, the stages run every cycle
	fp_adder_ctrl u_ctrl (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.done(done),
		.busy(busy)
	);

	// Unpack, compare exponents and classify specials
	fp_adder_stage1 u_stage1 (
		.clk(clk),
		.reset_n(reset_n),
		.operand1(operand1),
		.operand2(operand2),
		.add1(add1)
	);

	// Align the smaller operand
	fp_adder_stage2 u_stage2 (
		.clk(clk),
		.reset_n(reset_n),
		.add1(add1),
		.add2(add2)
	);

	// Add and convert to sign and magnitude
	fp_adder_stage3 u_stage3 (
		.clk(clk),
		.reset_n(reset_n),
		.add2(add2),
		.add3(add3)
	);

	// Normalize and pack the result word
	fp_adder_stage4 u_stage4 (
		.clk(clk),
		.reset_n(reset_n),
		.add3(add3),
		.result(result),
		.result_is_inf(result_is_inf),
		.result_is_nan(result_is_nan)
	);

endmodule

// File: testbench/fp_adder_tb.sv
`timescale 1ns/1ps
`include "fp_adder_cfg.svh"

module fp_adder_tb
	import fp_format_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 4;
	localparam int NUM_DIRECTED = 21;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_OPS = NUM_DIRECTED + NUM_RANDOM;
	// Each operation takes one start cycle, then the pipeline drains, with a margin of two
	localparam int WATCHDOG_NS = (NUM_OPS + `FP_ADD_LATENCY) * CLK_PERIOD * 2
		+ RESET_CYCLES * CLK_PERIOD;

	localparam fp_word_t QNAN = 32'h7FC0_0000;
	localparam fp_word_t SNAN = 32'h7F80_0001;
	localparam fp_word_t POS_INF = 32'h7F80_0000;
	localparam fp_word_t NEG_INF = 32'hFF80_0000;
	localparam fp_word_t NEG_ZERO = 32'h8000_0000;
	localparam fp_word_t MAX_NORMAL = 32'h7F7F_FFFF;

	// Expected outcome of one operation, word and flags side by side
	typedef struct packed {
		fp_word_t word;
		logic is_inf;
		logic is_nan;
	} expect_t;

	logic clk = 1'b0;
	logic reset_n;
	logic start;
	fp_word_t operand1;
	fp_word_t operand2;
	logic done;
	logic busy;
	fp_word_t result;
	logic result_is_inf;
	logic result_is_nan;

	expect_t expect_q[$];
	string name_q[$];
	expect_t head;
	string head_name;
	logic head_valid;
	int errors;
	int ops_issued;
	int unsigned lcg_state = 95;

	fp_adder u_dut (
		.clk(clk),
		.reset_n(reset_n),
		.start(start),
		.operand1(operand1),
		.operand2(operand2),
		.done(done),
		.busy(busy),
		.result(result),
		.result_is_inf(result_is_inf),
		.result_is_nan(result_is_nan)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Linear congruential generator, the high bits are the useful ones
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Signed integer below 2^20 in magnitude, with a random bit length for varied exponents
	function automatic int rand_small_int();
		int unsigned r;
		int width;
		int value;
		r = lcg_next();
		width = 1 + int'((r >> 16) % 20);
		value = int'((lcg_next() >> 8) & ((32'd1 << width) - 1));
		return r[31] ? -value : value;
	endfunction

	// Exact binary32 encoding of an integer, zero becomes +0
	function automatic fp_word_t int_to_fp(input int value);
		int unsigned mag;
		int msb;
		fp_fields_t f;
		f = '0;
		if (value == 0)
			return '0;
		f.sign = value < 0;
		mag = (value < 0) ? -value : value;
		msb = 0;
		for (int i = 0; i < 32; i++)
		begin
			if (mag[i])
				msb = i;
		end
		f.exponent = fp_exp_t'(`FP_BIAS + msb);
		// The hidden bit falls off the top when the value is cut to fraction width
		if (msb > `FP_FRAC_W)
			f.fraction = fp_frac_t'(mag >> (msb - `FP_FRAC_W));
		else
			f.fraction = fp_frac_t'(mag << (`FP_FRAC_W - msb));
		return f;
	endfunction

	function automatic expect_t make_expect(input fp_word_t word, input logic is_inf,
		input logic is_nan);
		expect_t e;
		e.word = word;
		e.is_inf = is_inf;
		e.is_nan = is_nan;
		return e;
	endfunction

	// Called on a falling edge, leaves start high for the next rising edge
	task automatic issue_op(input fp_word_t a, input fp_word_t b, input expect_t e,
		input string name);
		operand1 = a;
		operand2 = b;
		start = 1'b1;
		expect_q.push_back(e);
		name_q.push_back(name);
		ops_issued++;
		@(negedge clk);
	endtask

	// Integer operands small enough that the sum is exact in binary32
	task automatic add_ints(input int a, input int b, input string name);
		issue_op(int_to_fp(a), int_to_fp(b), make_expect(int_to_fp(a + b), 1'b0, 1'b0), name);
	endtask

	task automatic drain_pipeline();
		start = 1'b0;
		while (busy)
			@(negedge clk);
		assert (expect_q.size() == 0)
		else
		begin
			errors++;
			$display("%0d operations never produced a done strobe", expect_q.size());
		end
	endtask

	// The oldest expectation moves to the head while done is high
	// The checks on the next rising edge compare against it
	always @(negedge clk)
	begin
		if (done)
		begin
			if (expect_q.size() > 0)
			begin
				head = expect_q.pop_front();
				head_name = name_q.pop_front();
				head_valid = 1'b1;
			end
			else
				head_valid = 1'b0;
		end
	end

	check_pending: assert property (@(posedge clk) disable iff (!reset_n)
		done |-> head_valid)
		else
		begin
			errors++;
			$display("done strobe arrived with no operation pending");
		end

	check_word: assert property (@(posedge clk) disable iff (!reset_n)
		(done && head_valid) |-> (result == head.word))
		else
		begin
			errors++;
			$display("MISMATCH %s expected %08h actual %08h", head_name, head.word,
				$sampled(result));
		end

	check_flags: assert property (@(posedge clk) disable iff (!reset_n)
		(done && head_valid) |-> (result_is_inf == head.is_inf && result_is_nan == head.is_nan))
		else
		begin
			errors++;
			$display("MISMATCH %s_flags expected %b%b actual %b%b", head_name, head.is_inf,
				head.is_nan, $sampled(result_is_inf), $sampled(result_is_nan));
		end

	// One done per start, a fixed pipeline depth later
	check_done_timing: assert property (@(posedge clk) disable iff (!reset_n)
		done == $past(start, `FP_ADD_LATENCY))
		else
		begin
			errors++;
			$display("MISMATCH done_timing expected %b actual %b",
				$sampled($past(start, `FP_ADD_LATENCY)), $sampled(done));
		end

	// Busy covers every start still inside the four stages
	check_busy: assert property (@(posedge clk) disable iff (!reset_n)
		busy == ($past(start, 1) || $past(start, 2) || $past(start, 3) || $past(start, 4)))
		else
		begin
			errors++;
			$display("MISMATCH busy expected %b actual %b",
				$past(start, 1) || $past(start, 2) || $past(start, 3) || $past(start, 4),
				$sampled(busy));
		end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with %0d results outstanding", WATCHDOG_NS,
			expect_q.size());
		$display("tests failed");
		$finish;
	end

	initial
	begin
		int a;
		int b;
		reset_n = 1'b0;
		start = 1'b0;
		operand1 = '0;
		operand2 = '0;
		head = '0;
		head_name = "none";
		head_valid = 1'b0;
		errors = 0;
		ops_issued = 0;

		repeat (RESET_CYCLES) @(negedge clk);
		assert (!done && !busy && result == '0 && !result_is_inf && !result_is_nan)
		else
		begin
			errors++;
			$display("outputs are not cleared while reset is held");
		end
		reset_n = 1'b1;
		@(negedge clk);
		assert (!done && !busy && result == '0)
		else
		begin
			errors++;
			$display("outputs are not cleared after reset release");
		end

		// Exact sums of both signs, the last ones cancel most bits and need normalizing
		add_ints(3, 5, "sum_small");
		add_ints(100, 100, "sum_equal_exp");
		add_ints(-7, 2, "diff_neg");
		add_ints(1000001, -1000000, "diff_normalize");
		add_ints(-20, -12, "sum_both_neg");
		add_ints(1, -3, "diff_sign_flip");
		add_ints(65536, -65535, "diff_deep");

		add_ints(12345, -12345, "cancel");
		add_ints(0, 77, "add_zero");
		issue_op(int_to_fp(-9), NEG_ZERO, make_expect(int_to_fp(-9), 1'b0, 1'b0),
			"add_neg_zero");
		issue_op(NEG_ZERO, NEG_ZERO, make_expect('0, 1'b0, 1'b0), "neg_zero_pair");

		// The small operand is shifted out completely
		issue_op(int_to_fp(1 << 30), int_to_fp(1), make_expect(int_to_fp(1 << 30), 1'b0, 1'b0),
			"align_sat");
		issue_op(int_to_fp(1), int_to_fp(1 << 30), make_expect(int_to_fp(1 << 30), 1'b0, 1'b0),
			"align_sat_swap");
		issue_op(int_to_fp(-(1 << 30)), int_to_fp(-1),
			make_expect(int_to_fp(-(1 << 30)), 1'b0, 1'b0), "align_sat_neg");

		issue_op(QNAN, int_to_fp(1), make_expect(QNAN, 1'b0, 1'b1), "nan_first");
		issue_op(int_to_fp(1), SNAN, make_expect(QNAN, 1'b0, 1'b1), "nan_second");
		issue_op(POS_INF, NEG_INF, make_expect(QNAN, 1'b0, 1'b1), "inf_minus_inf");
		issue_op(POS_INF, int_to_fp(5), make_expect(POS_INF, 1'b1, 1'b0), "inf_plus_finite");
		issue_op(int_to_fp(3), NEG_INF, make_expect(NEG_INF, 1'b1, 1'b0), "finite_neg_inf");
		issue_op(MAX_NORMAL, MAX_NORMAL, make_expect(POS_INF, 1'b1, 1'b0), "overflow_pos");
		issue_op(MAX_NORMAL | NEG_ZERO, MAX_NORMAL | NEG_ZERO, make_expect(NEG_INF, 1'b1, 1'b0),
			"overflow_neg");
		drain_pipeline();

		// Back to back random sums, some of them exact cancellations
		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			a = rand_small_int();
			if (lcg_next() < 32'h2000_0000)
				b = -a;
			else
				b = rand_small_int();
			add_ints(a, b, "random_sum");
		end
		drain_pipeline();
		@(negedge clk);

		$display("%0d errors in %0d operations", errors, ops_issued);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: fp_adder.f
+incdir+verilog
verilog/fp_format_pkg.sv
verilog/fp_adder_pkg.sv
verilog/fp_adder_ctrl.sv
verilog/fp_adder_stage1.sv
verilog/fp_adder_stage2.sv
verilog/fp_adder_stage3.sv
verilog/fp_adder_stage4.sv
verilog/fp_adder.sv
testbench/fp_adder_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the log

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module fp_adder_tb \
	-f fp_adder.f -o fp_adder_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/fp_adder_sim > sim.log 2>&1 || echo "simulator returned an error status"

grep -q "^all tests passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
